//--- filelist.f
+incdir+include
design/noc_config_pkg.sv
design/noc_flit_pkg.sv
design/noc_input_unit.sv
design/noc_switch.sv
design/noc_router.sv
tests/tb_noc_router.sv

//--- run.sh
#!/usr/bin/env bash
# build the router testbench with verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_noc_router \
  -f filelist.f -Mdir obj_dir \
  && ./obj_dir/Vtb_noc_router | tee /dev/stderr | grep -x "Test passed" > /dev/null \
  && echo "simulation ok" \
  || { echo "simulation FAILED"; exit 1; }

//--- tests/tb_noc_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module tb_noc_router;

  localparam int SRC_BIT = `NOC_DATA_W - 1;  // input the flit came in on.

  logic                           clk;
  logic                           rst_n_i;
  logic                           in_valid  [2];  // 0 local, 1 west.
  noc_flit_pkg::flit_t            in_flit   [2];
  logic                           in_ready  [2];
  logic                           out_valid [2];  // 0 local, 1 forward.
  noc_flit_pkg::flit_t            out_flit  [2];
  logic                           out_ready [2];
  logic [1:0]                     sw_valid;
  logic [1:0]                     sw_ready;
  noc_flit_pkg::flit_req_t [1:0]  sw_req;
  logic                           in_pkt_q   [2];
  logic                           pkt_src_q  [2];
  logic                           last_ok_q  [2];
  logic                           last_src_q [2];  // input of the last tail granted.
  noc_flit_pkg::flit_t            send_q [2][$];
  noc_flit_pkg::flit_t            exp_q  [4][$];  // index src * 2 + out.
  int seed       = 32'h67d6;
  int limit      = 200;
  int ready_mode = 0;
  int error_cnt  = 0;
  int tx_cnt     = 0;
  int rx_cnt     = 0;
  int pkt_id     = 0;
  int pass_tests = 0;
  int fail_tests = 0;

  noc_router #(.MY_X(1), .MY_Y(1)) u_dut (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .local_in_valid_i  (in_valid[0]),
    .local_in_flit_i   (in_flit[0]),
    .local_in_ready_o  (in_ready[0]),
    .west_in_valid_i   (in_valid[1]),
    .west_in_flit_i    (in_flit[1]),
    .west_in_ready_o   (in_ready[1]),
    .local_out_valid_o (out_valid[0]),
    .local_out_flit_o  (out_flit[0]),
    .local_out_ready_i (out_ready[0]),
    .fwd_out_valid_o   (out_valid[1]),
    .fwd_out_flit_o    (out_flit[1]),
    .fwd_out_ready_i   (out_ready[1])
  );

  assign sw_valid = u_dut.req_valid;
  assign sw_ready = u_dut.req_ready;
  assign sw_req   = u_dut.req;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic void note_error(input string msg);
    $display("%s", msg);
    error_cnt++;
  endfunction

  task automatic make_packets(input int n_pkt, input bit all_local);
    noc_flit_pkg::flit_t     f;
    noc_config_pkg::coord_t  dest;
    int                      len;
    int                      port;
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < n_pkt; p++) begin
        len    = 1 + int'($unsigned($random(seed)) % 4);
        dest.x = `NOC_COORD_W'($random(seed));
        dest.y = `NOC_COORD_W'($random(seed));
        if (all_local || (($random(seed) & 1) == 0)) begin
          dest.x = `NOC_COORD_W'(1);
          dest.y = `NOC_COORD_W'(1);
        end
        port = (dest.x == 1 && dest.y == 1) ? 0 : 1;  // xy rule at node (1,1).
        pkt_id++;
        for (int k = 0; k < len; k++) begin
          f.head = (k == 0);
          f.tail = (k == len - 1);
          f.dest = dest;
          f.data = {s[0], 7'(pkt_id), 8'(k)};
          send_q[s].push_back(f);
          exp_q[s * 2 + port].push_back(f);
          tx_cnt++;
          limit += 20;
        end
      end
    end
  endtask

  task automatic send_all(input int src);
    while (send_q[src].size() != 0) begin
      @(negedge clk);
      in_valid[src] = 1'b1;
      in_flit[src]  = send_q[src][0];
      if (in_ready[src]) begin
        void'(send_q[src].pop_front());  // taken at the next rising edge.
      end
    end
    @(negedge clk);
    in_valid[src] = 1'b0;
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int k = 0; k < 4; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  task automatic report_test(input string name, input int err0);
    if (error_cnt == err0) begin
      pass_tests++;
    end else begin
      fail_tests++;
    end
    $display("%s: %0d errors", name, error_cnt - err0);
  endtask

  task automatic run_traffic(input string name, input int n_pkt, input bit all_local,
                             input int mode);
    int err0;
    err0 = error_cnt;
    @(posedge clk);
    ready_mode = mode;
    make_packets(n_pkt, all_local);
    fork
      send_all(0);
      send_all(1);
    join
    while (pending() != 0) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);  // a duplicate would land on an empty queue.
    a_count : assert (rx_cnt == tx_cnt)
      else note_error($sformatf("ERR rx_cnt exp=%h act=%h", tx_cnt, rx_cnt));
    report_test(name, err0);
  endtask

  // 0 always ready, 1 ready three cycles in four, 2 ready half the time.
  initial begin
    int rnd;
    forever begin
      @(negedge clk);
      for (int o = 0; o < 2; o++) begin
        rnd          = $random(seed);
        out_ready[o] = (ready_mode == 0) || (int'(rnd[1:0]) >= ready_mode);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_flit(input int o, input noc_flit_pkg::flit_t act);
    int k;
    k = int'(act.data[SRC_BIT]) * 2 + o;
    rx_cnt++;  // every transfer counts, expected or not.
    a_expected : assert (exp_q[k].size() != 0)
      else note_error($sformatf("output %0d sent flit %h that nobody expected", o, act));
    if (exp_q[k].size() != 0) begin
      a_flit : assert (act == exp_q[k][0])
        else note_error($sformatf("ERR %s exp=%h act=%h",
                                  (o == 0) ? "local_out_flit_o" : "fwd_out_flit_o",
                                  exp_q[k][0], act));
      void'(exp_q[k].pop_front());
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n_i) begin
      for (int o = 0; o < 2; o++) begin
        in_pkt_q[o]   <= 1'b0;
        pkt_src_q[o]  <= 1'b0;
        last_ok_q[o]  <= 1'b0;
        last_src_q[o] <= 1'b0;
      end
    end else begin
      for (int o = 0; o < 2; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          check_flit(o, out_flit[o]);
          in_pkt_q[o]  <= !out_flit[o].tail;
          pkt_src_q[o] <= out_flit[o].data[SRC_BIT];
        end
        for (int i = 0; i < 2; i++) begin
          if (sw_ready[i] && int'(sw_req[i].port) == o && sw_req[i].flit.tail) begin
            last_ok_q[o]  <= 1'b1;
            last_src_q[o] <= i[0];
          end
        end
      end
    end
  end

  a_reset_idle : assert property (@(posedge clk)
    !rst_n_i |=> !out_valid[0] && !out_valid[1] && in_ready[0] && in_ready[1])
    else note_error("outputs busy or inputs not ready during or right after reset");

  for (genvar g = 0; g < 2; g++) begin : g_out
    a_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
      out_valid[g] && !out_ready[g] |=> out_valid[g] && $stable(out_flit[g]))
      else note_error($sformatf("output %0d dropped or changed a held flit", g));

    a_whole_packet : assert property (@(posedge clk) disable iff (!rst_n_i)
      out_valid[g] && out_ready[g] && in_pkt_q[g] |->
        !out_flit[g].head && out_flit[g].data[SRC_BIT] == pkt_src_q[g])
      else note_error($sformatf("output %0d interleaved two packets", g));

    for (genvar h = 0; h < 2; h++) begin : g_in
      // after input h finishes a packet, a waiting other input goes next.
      a_fair : assert property (@(posedge clk) disable iff (!rst_n_i)
        sw_ready[h] && int'(sw_req[h].port) == g && sw_req[h].flit.head &&
        last_ok_q[g] && int'(last_src_q[g]) == h |->
          !(sw_valid[1 - h] && int'(sw_req[1 - h].port) == g))
        else note_error($sformatf("output %0d granted input %0d twice in a row", g, h));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequence and report.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int cyc;
    cyc = 0;
    while (cyc <= limit) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout after %0d cycles with %0d flits still undelivered", cyc, pending());
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n_i = 1'b0;
    for (int i = 0; i < 2; i++) begin
      in_valid[i]  = 1'b0;
      in_flit[i]   = '0;
      out_ready[i] = 1'b1;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    repeat (2) @(posedge clk);
    report_test("reset_state", 0);
    run_traffic("local_forward", 8, 1'b0, 0);
    run_traffic("backpressure", 10, 1'b0, 2);
    run_traffic("fairness", 10, 1'b1, 1);
    $display("tests: %0d pass, %0d fail", pass_tests, fail_tests);
    if (fail_tests == 0 && error_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/noc_router.sv
`timescale 1ns/1ns
`default_nettype none

module noc_router #(
  parameter int unsigned MY_X = 0,
  parameter int unsigned MY_Y = 0
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  // from the attached core.
  input  logic                 local_in_valid_i,
  input  noc_flit_pkg::flit_t  local_in_flit_i,
  output logic                 local_in_ready_o,
  // from the west neighbor.
  input  logic                 west_in_valid_i,
  input  noc_flit_pkg::flit_t  west_in_flit_i,
  output logic                 west_in_ready_o,
  // eject to the core.
  output logic                 local_out_valid_o,
  output noc_flit_pkg::flit_t  local_out_flit_o,
  input  logic                 local_out_ready_i,
  // toward the next node.
  output logic                 fwd_out_valid_o,
  output noc_flit_pkg::flit_t  fwd_out_flit_o,
  input  logic                 fwd_out_ready_i
);

  // index 0 is the local input, index 1 the west input.
  logic [1:0]                     req_valid;
  noc_flit_pkg::flit_req_t [1:0]  req;
  logic [1:0]                     req_ready;

  noc_input_unit #(
    .MY_X (MY_X),
    .MY_Y (MY_Y)
  ) u_in_local (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (local_in_valid_i),
    .in_flit_i   (local_in_flit_i),
    .in_ready_o  (local_in_ready_o),
    .req_valid_o (req_valid[0]),
    .req_o       (req[0]),
    .req_ready_i (req_ready[0])
  );

  noc_input_unit #(
    .MY_X (MY_X),
    .MY_Y (MY_Y)
  ) u_in_west (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (west_in_valid_i),
    .in_flit_i   (west_in_flit_i),
    .in_ready_o  (west_in_ready_o),
    .req_valid_o (req_valid[1]),
    .req_o       (req[1]),
    .req_ready_i (req_ready[1])
  );

  noc_switch u_switch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid),
    .req_i         (req),
    .req_ready_o   (req_ready),
    .local_valid_o (local_out_valid_o),
    .local_flit_o  (local_out_flit_o),
    .local_ready_i (local_out_ready_i),
    .fwd_valid_o   (fwd_out_valid_o),
    .fwd_flit_o    (fwd_out_flit_o),
    .fwd_ready_i   (fwd_out_ready_i)
  );

endmodule

`default_nettype wire

//--- design/noc_switch.sv
`timescale 1ns/1ns
`default_nettype none

module noc_switch (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic [1:0]                     req_valid_i,
  input  noc_flit_pkg::flit_req_t [1:0]  req_i,
  output logic [1:0]                     req_ready_o,
  output logic                           local_valid_o,
  output noc_flit_pkg::flit_t            local_flit_o,
  input  logic                           local_ready_i,
  output logic                           fwd_valid_o,
  output noc_flit_pkg::flit_t            fwd_flit_o,
  input  logic                           fwd_ready_i
);

  localparam int N_IN  = 2;
  localparam int N_OUT = 2;
  localparam int IDX_W = $clog2(N_IN);

  localparam int LOC = int'(noc_config_pkg::OUT_LOCAL);
  localparam int FWD = int'(noc_config_pkg::OUT_FORWARD);

  typedef logic [IDX_W-1:0] idx_t;

  logic [N_IN-1:0]      port_req [N_OUT];  // inputs asking for each output.
  logic [N_IN-1:0]      grant    [N_OUT];
  logic [N_OUT-1:0]     pick_valid;
  idx_t                 pick_idx [N_OUT];
  logic [N_OUT-1:0]     load;
  noc_flit_pkg::flit_t  win_flit [N_OUT];
  logic [N_OUT-1:0]     out_ready;

  logic [N_OUT-1:0]     out_valid_q;
  noc_flit_pkg::flit_t  out_flit_q [N_OUT];
  logic [N_OUT-1:0]     lock_q;            // packet in flight on this output.
  idx_t                 lock_idx_q [N_OUT];
  idx_t                 prio_q     [N_OUT]; // input favored next.

  assign out_ready[LOC] = local_ready_i;
  assign out_ready[FWD] = fwd_ready_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arbitration.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    idx_t cand;
    cand        = '0;
    req_ready_o = '0;
    for (int o = 0; o < N_OUT; o++) begin
      for (int i = 0; i < N_IN; i++) begin
        port_req[o][i] = req_valid_i[i] && (int'(req_i[i].port) == o);
      end
      pick_valid[o] = 1'b0;
      pick_idx[o]   = prio_q[o];
      if (lock_q[o]) begin
        pick_valid[o] = port_req[o][lock_idx_q[o]];  // owner only, may stall.
        pick_idx[o]   = lock_idx_q[o];
      end else begin
        // scan down so the favored input wins last.
        for (int k = N_IN - 1; k >= 0; k--) begin
          cand = idx_t'((int'(prio_q[o]) + k) % N_IN);
          if (port_req[o][cand]) begin
            pick_valid[o] = 1'b1;
            pick_idx[o]   = cand;
          end
        end
      end
      load[o] = pick_valid[o] && (!out_valid_q[o] || out_ready[o]);
      for (int i = 0; i < N_IN; i++) begin
        grant[o][i]    = load[o] && (pick_idx[o] == idx_t'(i));
        req_ready_o[i] = req_ready_o[i] | grant[o][i];
      end
      win_flit[o] = req_i[pick_idx[o]].flit;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_valid_q <= '0;
      lock_q      <= '0;
      for (int o = 0; o < N_OUT; o++) begin
        lock_idx_q[o] <= '0;
        prio_q[o]     <= '0;  // local input first.
      end
    end else begin
      for (int o = 0; o < N_OUT; o++) begin
        if (load[o]) begin
          out_valid_q[o] <= 1'b1;
          if (win_flit[o].tail) begin
            lock_q[o] <= 1'b0;
            prio_q[o] <= idx_t'((int'(pick_idx[o]) + 1) % N_IN);
          end else begin
            lock_q[o]     <= 1'b1;
            lock_idx_q[o] <= pick_idx[o];
          end
        end else if (out_ready[o]) begin
          out_valid_q[o] <= 1'b0;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output registers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    for (int o = 0; o < N_OUT; o++) begin
      if (load[o]) begin
        out_flit_q[o] <= win_flit[o];
      end
    end
  end

  assign local_valid_o = out_valid_q[LOC];
  assign local_flit_o  = out_flit_q[LOC];
  assign fwd_valid_o   = out_valid_q[FWD];
  assign fwd_flit_o    = out_flit_q[FWD];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar g_o = 0; g_o < N_OUT; g_o++) begin : g_out_chk
    // at most one winner, and never anyone but the lock owner.
    a_grant_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(grant[g_o]) &&
      (!lock_q[g_o] || grant[g_o] == '0 || grant[g_o][lock_idx_q[g_o]]));

    a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
      out_valid_q[g_o] && !out_ready[g_o] |=>
        out_valid_q[g_o] && $stable(out_flit_q[g_o]));
  end

  for (genvar g_i = 0; g_i < N_IN; g_i++) begin : g_in_chk
    a_single_output : assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0({grant[FWD][g_i], grant[LOC][g_i]}));
  end

endmodule

`default_nettype wire

//--- design/noc_input_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module noc_input_unit #(
  parameter int unsigned MY_X = 0,
  parameter int unsigned MY_Y = 0
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     in_valid_i,
  input  noc_flit_pkg::flit_t      in_flit_i,
  output logic                     in_ready_o,
  output logic                     req_valid_o,
  output noc_flit_pkg::flit_req_t  req_o,
  input  logic                     req_ready_i
);

  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  localparam noc_config_pkg::coord_t MY_COORD = '{
    x: `NOC_COORD_W'(MY_X),
    y: `NOC_COORD_W'(MY_Y)
  };

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input fifo.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  noc_flit_pkg::flit_t  mem_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [PTR_W:0]       count_q;
  logic                 full;
  logic                 empty;
  logic                 push;
  logic                 pop;

  assign full  = (count_q == (PTR_W + 1)'(DEPTH));
  assign empty = (count_q == '0);

  assign in_ready_o  = !full;
  assign req_valid_o = !empty;

  assign push = in_valid_i && in_ready_o;
  assign pop  = req_valid_o && req_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_flit_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // xy route.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  noc_flit_pkg::flit_t        head_flit;
  noc_config_pkg::out_port_e  head_route;
  noc_config_pkg::out_port_e  route_q;

  assign head_flit = mem_q[rd_ptr_q];

  // only two outputs on this slice, so anything not for us goes forward.
  assign head_route = (head_flit.dest == MY_COORD) ? noc_config_pkg::OUT_LOCAL
                                                    : noc_config_pkg::OUT_FORWARD;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      route_q <= noc_config_pkg::OUT_LOCAL;
    end else if (pop && head_flit.head) begin
      route_q <= head_route;  // held for body and tail.
    end
  end

  assign req_o.flit = head_flit;
  assign req_o.port = head_flit.head ? head_route : route_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a push into a full buffer would move the write pointer.
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n_i)
    full && !pop |=> full && $stable(wr_ptr_q));

  // a pop from an empty buffer would move the read pointer.
  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n_i)
    empty && !push |=> empty && $stable(rd_ptr_q));

endmodule

`default_nettype wire

//--- design/noc_flit_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_flit_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit format.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // head and tail both set for a single-flit packet.
  typedef struct packed {
    logic                    head;  // first flit of a packet.
    logic                    tail;  // last flit of a packet.
    noc_config_pkg::coord_t  dest;  // only looked at on head flits.
    logic [`NOC_DATA_W-1:0]  data;
  } flit_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input unit to switch.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    flit_t                      flit;
    noc_config_pkg::out_port_e  port;  // route held for the whole packet.
  } flit_req_t;

endpackage

`default_nettype wire

//--- design/noc_config_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_config_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // node addressing.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [`NOC_COORD_W-1:0] x;  // column.
    logic [`NOC_COORD_W-1:0] y;  // row.
  } coord_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output port selection.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [0:0] {
    OUT_LOCAL   = 1'b0,  // eject to the attached core.
    OUT_FORWARD = 1'b1   // pass on toward the next node.
  } out_port_e;

endpackage

`default_nettype wire

//--- include/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mesh geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define NOC_COORD_W 2     // bits per x or y coordinate.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flit payload and buffering.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define NOC_DATA_W 16     // payload bits per flit.

`define NOC_FIFO_DEPTH 4  // entries per input buffer.

`endif
